/* build.f */
+incdir+logic
logic/convDataPkg.sv
logic/convCtrlPkg.sv
logic/convController.sv
logic/rowWindowBuffer.sv
logic/weightStore.sv
logic/windowMultiplier.sv
logic/convEngine.sv
tb/convEngine_sva.sv
tb/convEngineTb.sv

/* logic/convController.sv */
`timescale 1ns/1ps

module convController (
	input  logic                  clk,
	input  logic                  rst,
	input  convCtrlPkg::command_t command,
	input  logic                  pixelValid,
	input  logic                  weightValid,
	output logic                  rowShift,
	output logic                  weightWrite,
	output logic                  weightClear,
	output logic                  computing,
	output logic                  finish
);

	convCtrlPkg::engineState_t state;
	convCtrlPkg::engineState_t nextState;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= convCtrlPkg::stWait;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			convCtrlPkg::stWait: begin
				if (command == convCtrlPkg::cmdStart) begin
					nextState = convCtrlPkg::stCompute;
				end else if (command == convCtrlPkg::cmdEnd) begin
					nextState = convCtrlPkg::stFinish;
				end
			end
			convCtrlPkg::stCompute: begin
				if (command == convCtrlPkg::cmdHold) begin
					nextState = convCtrlPkg::stWait;
				end else if (command == convCtrlPkg::cmdEnd) begin
					nextState = convCtrlPkg::stFinish;
				end
			end
			convCtrlPkg::stFinish: nextState = convCtrlPkg::stFinish;  // Left only by reset
			default: nextState = convCtrlPkg::stWait;
		endcase
	end

	// Pixels win over weights when both are offered
	assign rowShift    = (state == convCtrlPkg::stWait) && pixelValid;
	assign weightWrite = (state == convCtrlPkg::stWait) && weightValid && !pixelValid;
	assign computing   = (state == convCtrlPkg::stCompute);
	assign weightClear = computing && (command == convCtrlPkg::cmdHold);
	assign finish      = (state == convCtrlPkg::stFinish);

endmodule

/* logic/convCtrlPkg.sv */
package convCtrlPkg;

	typedef enum logic [1:0] {
		cmdEnd   = 2'd0,
		cmdStart = 2'd1,
		cmdHold  = 2'd2,
		cmdIdle  = 2'd3     // No request
	} command_t;

	typedef enum logic [1:0] {
		stWait,
		stCompute,
		stFinish
	} engineState_t;

endpackage

/* logic/convDataPkg.sv */
`include "conv_consts.svh"

package convDataPkg;

	typedef logic [`PIXEL_BITS-1:0] pixel_t;

	typedef logic [`ROW_PIXELS*`PIXEL_BITS-1:0] row_t;                // Pixel k at bits 8k
	typedef logic [3*`ROW_PIXELS*`PIXEL_BITS-1:0] window_t;           // Oldest row in low bits

	typedef logic [`KERNEL_TAPS*`PIXEL_BITS-1:0] filter_t;            // Tap j at bits 8j
	typedef logic [`ROW_PIXELS*`PIXEL_BITS-1:0] weightBeat_t;

	typedef logic [`KERNEL_TAPS*`PRODUCT_BITS-1:0] products_t;        // Product j at bits 16j

	// Cube c = filter * 8 + position at bits 144c
	typedef logic [`FILTER_COUNT*`ROW_PIXELS*`KERNEL_TAPS*`PRODUCT_BITS-1:0] productBus_t;

endpackage

/* logic/convEngine.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module convEngine (
	input  logic                     clk,
	input  logic                     rst,
	input  convCtrlPkg::command_t    command,
	input  convDataPkg::row_t        pixelRow,
	input  logic                     pixelValid,
	input  convDataPkg::weightBeat_t weightBeat,
	input  logic                     weightValid,
	output convDataPkg::productBus_t products,
	output logic                     productValid,
	output logic                     finish
);

	localparam int cubeBits = $bits(convDataPkg::products_t);

	logic rowShift;
	logic weightWrite;
	logic weightClear;
	logic computing;

	convDataPkg::window_t window;
	convDataPkg::filter_t filter0;
	convDataPkg::filter_t filter1;
	convDataPkg::filter_t filters [`FILTER_COUNT];

	convController controller (
		.clk        (clk),
		.rst        (rst),
		.command    (command),
		.pixelValid (pixelValid),
		.weightValid(weightValid),
		.rowShift   (rowShift),
		.weightWrite(weightWrite),
		.weightClear(weightClear),
		.computing  (computing),
		.finish     (finish)
	);

	rowWindowBuffer rowBuffer (
		.clk      (clk),
		.rst      (rst),
		.rowShift (rowShift),
		.computing(computing),
		.pixelRow (pixelRow),
		.window   (window)
	);

	weightStore weights (
		.clk        (clk),
		.rst        (rst),
		.weightWrite(weightWrite),
		.weightClear(weightClear),
		.computing  (computing),
		.weightBeat (weightBeat),
		.filter0    (filter0),
		.filter1    (filter1)
	);

	assign filters[0] = filter0;
	assign filters[1] = filter1;

	// Cube index is filter * 8 + position
	for (genvar f = 0; f < `FILTER_COUNT; f++) begin : gFilter
		for (genvar p = 0; p < `ROW_PIXELS; p++) begin : gPosition
			windowMultiplier #(.position(p)) cube (
				.window  (window),
				.filter  (filters[f]),
				.products(products[(f*`ROW_PIXELS + p)*cubeBits +: cubeBits])
			);
		end
	end

	assign productValid = computing;

endmodule

/* logic/conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Pixel and weight width
`define PIXEL_BITS 8

// Pixels in one 64-bit row
`define ROW_PIXELS 8

// Depth of the row window buffer
`define ROW_COUNT 8

// 3x3 window
`define KERNEL_TAPS 9

`define FILTER_COUNT 2

// 64-bit beats needed to cover both filters
`define WEIGHT_BEATS 3

// Unsigned 8x8 product
`define PRODUCT_BITS 16

`endif

/* logic/rowWindowBuffer.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module rowWindowBuffer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rowShift,
	input  logic                 computing,
	input  convDataPkg::row_t    pixelRow,
	output convDataPkg::window_t window
);

	localparam int lastRow = `ROW_COUNT - 1;

	// Slot 0 holds the oldest row
	convDataPkg::row_t rows [`ROW_COUNT];
	convDataPkg::row_t youngestIn;

	// Rotation feeds the oldest row back in
	assign youngestIn = computing ? rows[0] : pixelRow;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `ROW_COUNT; i++) begin
				rows[i] <= '0;
			end
		end else if (rowShift || computing) begin
			for (int i = 0; i < lastRow; i++) begin
				rows[i] <= rows[i+1];       // Move toward oldest slot
			end
			rows[lastRow] <= youngestIn;
		end
	end

	// Three oldest rows, oldest in the low bits
	assign window = {rows[2], rows[1], rows[0]};

endmodule

/* logic/weightStore.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module weightStore (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     weightWrite,
	input  logic                     weightClear,
	input  logic                     computing,
	input  convDataPkg::weightBeat_t weightBeat,
	output convDataPkg::filter_t     filter0,
	output convDataPkg::filter_t     filter1
);

	localparam int beatBits   = $bits(convDataPkg::weightBeat_t);
	localparam int filterBits = $bits(convDataPkg::filter_t);
	localparam int countBits  = $clog2(`WEIGHT_BEATS + 1);

	logic [`WEIGHT_BEATS*beatBits-1:0] weightReg;   // Filter 0 in the low 72 bits
	logic [countBits-1:0]              beatCount;   // Next beat slot
	logic                              roomLeft;

	assign roomLeft = (beatCount < countBits'(`WEIGHT_BEATS));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			weightReg <= '0;
			beatCount <= '0;
		end else if (weightClear) begin
			weightReg <= '0;                             // Hold drops the bank
			beatCount <= '0;
		end else if (weightWrite && roomLeft) begin
			weightReg[beatCount*beatBits +: beatBits] <= weightBeat;
			beatCount <= beatCount + 1'b1;
		end
	end

	// Taps read as zero outside compute, so products do too
	assign filter0 = computing ? weightReg[0 +: filterBits] : '0;
	assign filter1 = computing ? weightReg[filterBits +: filterBits] : '0;

endmodule

/* logic/windowMultiplier.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module windowMultiplier #(
	parameter int position = 0              // Column 0 to 7
) (
	input  convDataPkg::window_t   window,
	input  convDataPkg::filter_t   filter,
	output convDataPkg::products_t products
);

	localparam int rowBits    = $bits(convDataPkg::row_t);
	localparam int kernelSide = 3;

	for (genvar j = 0; j < `KERNEL_TAPS; j++) begin : gTap
		// Tap j reads row j/3, columns wrap at the row edge
		localparam int rowSel = j / kernelSide;
		localparam int colSel = (position + j % kernelSide) % `ROW_PIXELS;
		localparam int pixelLsb = rowSel * rowBits + colSel * `PIXEL_BITS;

		convDataPkg::pixel_t tapPixel;
		convDataPkg::pixel_t tapWeight;

		assign tapPixel  = window[pixelLsb +: `PIXEL_BITS];
		assign tapWeight = filter[j*`PIXEL_BITS +: `PIXEL_BITS];

		// Unsigned, left unsummed
		assign products[j*`PRODUCT_BITS +: `PRODUCT_BITS] =
			`PRODUCT_BITS'(tapPixel) * `PRODUCT_BITS'(tapWeight);
	end

endmodule

/* tb/convEngineTb.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"

module convEngineTb;

	localparam int cycleLimit = 400;    // Whole flow runs in about 80 cycles
	localparam int busBits    = $bits(convDataPkg::productBus_t);
	localparam int beatBits   = $bits(convDataPkg::weightBeat_t);

	logic                     clk;
	logic                     rst;
	convCtrlPkg::command_t    command;
	convDataPkg::row_t        pixelRow;
	logic                     pixelValid;
	convDataPkg::weightBeat_t weightBeat;
	logic                     weightValid;
	convDataPkg::productBus_t products;
	logic                     productValid;
	logic                     finish;

	// Model of what the DUT should hold
	convDataPkg::row_t           modelRows [`ROW_COUNT];   // Slot 0 oldest
	logic [`WEIGHT_BEATS*beatBits-1:0] modelWeights;
	int                          modelBeats;
	int                          rotations;                // Compute edges since last align
	int                          cycleCount = 0;

	convEngine uut (
		.clk         (clk),
		.rst         (rst),
		.command     (command),
		.pixelRow    (pixelRow),
		.pixelValid  (pixelValid),
		.weightBeat  (weightBeat),
		.weightValid (weightValid),
		.products    (products),
		.productValid(productValid),
		.finish      (finish)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("SIMULATION FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// Bound assertions count their failures
	always @(uut.assertions.failCount) begin
		if (uut.assertions.failCount != 0) begin
			$display("A bound assertion failed in cycle %0d", cycleCount);
			$display("SIMULATION FAILED");
			$fatal(1, "Assertion failure during the run");
		end
	end

	task automatic checkValue(input string testName, input logic [busBits-1:0] expected,
			input logic [busBits-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %0h, actual %0h", testName, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "Check failed in %s", testName);
		end
	endtask

	// Inputs change 1 ns after the edge
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	function automatic convDataPkg::row_t randomRow();
		return {$urandom(), $urandom()};
	endfunction

	// Window rows k, k+1, k+2 mod 8, columns wrap at the row edge
	function automatic convDataPkg::productBus_t expectedProducts(input int rot);
		convDataPkg::productBus_t result;
		convDataPkg::pixel_t      pixel;
		convDataPkg::pixel_t      weight;
		int                       rowIdx;
		int                       col;
		int                       cube;
		result = '0;
		for (int f = 0; f < `FILTER_COUNT; f++) begin
			for (int p = 0; p < `ROW_PIXELS; p++) begin
				cube = f * `ROW_PIXELS + p;
				for (int j = 0; j < `KERNEL_TAPS; j++) begin
					rowIdx = (rot + j / 3) % `ROW_COUNT;
					col    = (p + j % 3) % `ROW_PIXELS;
					pixel  = modelRows[rowIdx][col*`PIXEL_BITS +: `PIXEL_BITS];
					weight = modelWeights[(f*`KERNEL_TAPS + j)*`PIXEL_BITS +: `PIXEL_BITS];
					result[(cube*`KERNEL_TAPS + j)*`PRODUCT_BITS +: `PRODUCT_BITS] =
						`PRODUCT_BITS'(pixel) * `PRODUCT_BITS'(weight);
				end
			end
		end
		return result;
	endfunction

	// Fold pending rotations into the model before rows shift in
	task automatic alignRows();
		convDataPkg::row_t rotated [`ROW_COUNT];
		for (int i = 0; i < `ROW_COUNT; i++) begin
			rotated[i] = modelRows[(i + rotations) % `ROW_COUNT];
		end
		modelRows = rotated;
		rotations = 0;
	endtask

	task automatic shiftModelRow(input convDataPkg::row_t row);
		alignRows();
		for (int i = 0; i < `ROW_COUNT - 1; i++) begin
			modelRows[i] = modelRows[i+1];
		end
		modelRows[`ROW_COUNT-1] = row;
	endtask

	task automatic clearModelWeights();
		modelWeights = '0;
		modelBeats   = 0;
	endtask

	task automatic loadRow(input convDataPkg::row_t row);
		pixelRow   = row;
		pixelValid = 1'b1;
		nextCycle();
		pixelValid = 1'b0;
		shiftModelRow(row);
	endtask

	task automatic loadBeat(input convDataPkg::weightBeat_t beat);
		weightBeat  = beat;
		weightValid = 1'b1;
		nextCycle();
		weightValid = 1'b0;
		if (modelBeats < `WEIGHT_BEATS) begin     // Extra beats are dropped
			modelWeights[modelBeats*beatBits +: beatBits] = beat;
			modelBeats++;
		end
	endtask

	task automatic startCompute();
		command = convCtrlPkg::cmdStart;
		nextCycle();
		command = convCtrlPkg::cmdIdle;
	endtask

	// Checks each compute cycle, lastCommand goes out in the final one
	task automatic computeCycles(input string testName, input int count,
			input convCtrlPkg::command_t lastCommand);
		for (int k = 0; k < count; k++) begin
			if (k == count - 1) begin
				command = lastCommand;
			end
			@(negedge clk);
			checkValue(testName, busBits'(1'b1), busBits'(productValid));
			checkValue(testName, expectedProducts(rotations), products);
			nextCycle();
			rotations++;                        // Rows rotate on every compute edge
			command = convCtrlPkg::cmdIdle;
		end
		if (lastCommand == convCtrlPkg::cmdHold) begin
			clearModelWeights();
		end
	endtask

	task automatic checkIdle(input string testName);
		@(negedge clk);
		checkValue(testName, '0, busBits'(productValid));
		checkValue(testName, '0, products);
		nextCycle();
	endtask

	task automatic testAfterReset();
		@(negedge clk);
		checkValue("afterReset", '0, busBits'(productValid));
		checkValue("afterReset", '0, busBits'(finish));
		checkValue("afterReset", '0, products);
		nextCycle();
	endtask

	task automatic testLoadAndStart();
		for (int i = 0; i < `ROW_COUNT; i++) begin
			loadRow(randomRow());
		end
		for (int i = 0; i < `WEIGHT_BEATS; i++) begin
			loadBeat(randomRow());
		end
		startCompute();
		computeCycles("loadAndStart", `ROW_COUNT, convCtrlPkg::cmdHold);
		checkIdle("loadAndStart");
	endtask

	task automatic testPixelPriority();
		convDataPkg::row_t row;
		loadBeat(randomRow());
		row         = randomRow();
		pixelRow    = row;
		weightBeat  = randomRow();              // Must lose to the row
		pixelValid  = 1'b1;
		weightValid = 1'b1;
		nextCycle();
		pixelValid  = 1'b0;
		weightValid = 1'b0;
		shiftModelRow(row);
		loadBeat(randomRow());
		loadBeat(randomRow());
		startCompute();
		computeCycles("pixelPriority", 3, convCtrlPkg::cmdIdle);
	endtask

	task automatic testHold();
		computeCycles("hold", 2, convCtrlPkg::cmdHold);
		checkIdle("hold");
		startCompute();
		computeCycles("holdRestart", 4, convCtrlPkg::cmdHold);   // Weights gone, all zero
		for (int i = 0; i < `WEIGHT_BEATS; i++) begin
			loadBeat(randomRow());
		end
		// New weights expose the rotated row order
		startCompute();
		computeCycles("holdRotation", `ROW_COUNT, convCtrlPkg::cmdIdle);
	endtask

	task automatic testEnd();
		command = convCtrlPkg::cmdEnd;
		nextCycle();
		for (int i = 0; i < 10; i++) begin
			command     = convCtrlPkg::command_t'(2'($urandom_range(0, 3)));
			pixelRow    = randomRow();
			weightBeat  = randomRow();
			pixelValid  = 1'($urandom_range(0, 1));
			weightValid = 1'($urandom_range(0, 1));
			@(negedge clk);
			checkValue("end", busBits'(1'b1), busBits'(finish));
			checkValue("end", '0, busBits'(productValid));
			checkValue("end", '0, products);
			nextCycle();
		end
		command     = convCtrlPkg::cmdIdle;
		pixelValid  = 1'b0;
		weightValid = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hc467_8f0b));
		rst         = 1'b1;
		command     = convCtrlPkg::cmdIdle;
		pixelRow    = '0;
		pixelValid  = 1'b0;
		weightBeat  = '0;
		weightValid = 1'b0;
		rotations   = 0;
		clearModelWeights();
		for (int i = 0; i < `ROW_COUNT; i++) begin
			modelRows[i] = '0;                  // Reset clears the rows
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		testAfterReset();
		testLoadAndStart();
		testPixelPriority();
		testHold();
		testEnd();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* tb/convEngine_sva.sv */
`timescale 1ns/1ps

module convEngine_sva (
	input logic                     clk,
	input logic                     rst,
	input logic                     productValid,
	input logic                     finish,
	input convDataPkg::productBus_t products
);

	int failCount = 0;      // Failed assertions so far

	// Finish is sticky until reset
	finishSticky: assert property (@(posedge clk) disable iff (rst) finish |=> finish)
		else begin
			$error("finish fell while reset was low");
			failCount++;
		end

	validNotFinish: assert property (@(posedge clk) disable iff (rst) !(productValid && finish))
		else begin
			$error("productValid and finish were high in the same cycle");
			failCount++;
		end

	// Idle multipliers see zero taps
	zeroWhenIdle: assert property (@(posedge clk) disable iff (rst) !productValid |-> products == '0)
		else begin
			$error("products were not zero while productValid was low");
			failCount++;
		end

endmodule

bind convEngine convEngine_sva assertions (
	.clk         (clk),
	.rst         (rst),
	.productValid(productValid),
	.finish      (finish),
	.products    (products)
);
